/* design/sdram_sched_pkg.sv */
package sdram_sched_pkg;

  // ----------------------------------------------------------------------
  // SDRAM command encodings {ras_n, cas_n, we_n}
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    ACTV = 3'b011, // row open
    READ = 3'b101,
    WRTE = 3'b100,
    BTRM = 3'b110, // burst terminate, never issued here
    PRCH = 3'b010, // row close
    ARSR = 3'b001, // auto refresh
    MRST = 3'b000  // mode register set, never issued here
  } sdram_cmd_e;

  // ----------------------------------------------------------------------
  // address fields, request address is {row, bank, column}
  // ----------------------------------------------------------------------
  localparam int ADDR_W    = 26;
  localparam int ROW_W     = 12;
  localparam int BANK_W    = 2;
  localparam int COL_W     = 12;
  localparam int PAGE_W    = ROW_W + BANK_W;
  localparam int SD_ADDR_W = 13;
  localparam int WE_W      = 4;

  // auto precharge / precharge-all bit of the SDRAM address
  localparam int AP_BIT = 10;
  localparam logic [SD_ADDR_W-1:0] PRCH_ALL_ADDR = SD_ADDR_W'(1) << AP_BIT;

  // ----------------------------------------------------------------------
  // command spacing
  // ----------------------------------------------------------------------
  localparam int CNT_W = 4;
  localparam logic [CNT_W-1:0] CNT_RELOAD_ARSR = 4'd3;
  localparam logic [CNT_W-1:0] CNT_RELOAD_CMD  = 4'd12;
  localparam logic [CNT_W-1:0] CNT_RELOAD_IDLE = 4'd14;
  localparam logic [CNT_W-1:0] CNT_DONE_NORM   = 4'd13; // 13 or 14
  localparam logic [CNT_W-1:0] CNT_DONE_DELAY  = 4'd15; // 15 or wrapped 0

  // activate timer, top bit set once tRAS has passed
  localparam int ACTV_W = 3;
  localparam logic [ACTV_W-1:0] ACTV_MIN = 3'b100;

endpackage

/* design/page_hit_decode.sv */
`timescale 1ns/1ps

module page_hit_decode (
  input  logic [sdram_sched_pkg::ADDR_W-1:0]    rand_address,
  input  logic                                  rand_request,
  input  logic                                  rand_we,
  input  logic [sdram_sched_pkg::ADDR_W-1:0]    bulk_address,
  input  logic                                  bulk_request,
  input  logic                                  bulk_we,
  input  logic                                  page_open,
  input  logic [sdram_sched_pkg::PAGE_W-1:0]    open_page,
  input  logic                                  refresh_pending,
  output logic                                  hit_rand,
  output logic                                  hit_bulk,
  output logic                                  hit_any,
  output logic                                  access_write,
  output logic [sdram_sched_pkg::PAGE_W-1:0]    next_page,
  output logic [sdram_sched_pkg::SD_ADDR_W-1:0] next_sd_addr,
  output logic [sdram_sched_pkg::BANK_W-1:0]    next_bank
);

  logic [sdram_sched_pkg::PAGE_W-1:0] rand_page;
  logic [sdram_sched_pkg::PAGE_W-1:0] bulk_page;
  logic [sdram_sched_pkg::PAGE_W-1:0] src_page;
  logic [sdram_sched_pkg::ADDR_W-1:0] src_address;
  logic [sdram_sched_pkg::ROW_W-1:0]  src_row;
  logic [sdram_sched_pkg::COL_W-1:0]  src_col;
  logic                               access_ok;

  // row and bank sit in the top address bits
  assign rand_page = rand_address[sdram_sched_pkg::ADDR_W-1 -: sdram_sched_pkg::PAGE_W];
  assign bulk_page = bulk_address[sdram_sched_pkg::ADDR_W-1 -: sdram_sched_pkg::PAGE_W];

  // no access while a refresh waits or with the page closed
  assign access_ok = page_open && !refresh_pending;

  assign hit_bulk = bulk_request && access_ok && (bulk_page == open_page);
  assign hit_rand = rand_request && !bulk_request && access_ok &&
                    (rand_page == open_page); // bulk masks random
  assign hit_any  = hit_rand || hit_bulk;

  assign access_write = bulk_request ? bulk_we : (rand_request && rand_we);

  // ----------------------------------------------------------------------
  // address source, bulk first
  // ----------------------------------------------------------------------
  assign src_address = bulk_request ? bulk_address : rand_address;
  assign src_page    = src_address[sdram_sched_pkg::ADDR_W-1 -: sdram_sched_pkg::PAGE_W];
  assign src_row     = src_address[sdram_sched_pkg::ADDR_W-1 -: sdram_sched_pkg::ROW_W];
  assign src_col     = src_address[sdram_sched_pkg::COL_W-1:0];

  always_comb
  begin
    if (hit_any)
    begin
      // column address, 16-bit halves
      next_sd_addr = {src_col, 1'b0};
      next_page    = open_page;
      next_bank    = open_page[sdram_sched_pkg::BANK_W-1:0];
    end
    else
    begin
      // row address, AP bit kept clear
      next_sd_addr = {src_row[sdram_sched_pkg::ROW_W-1:sdram_sched_pkg::AP_BIT],
                      1'b0,
                      src_row[sdram_sched_pkg::AP_BIT-1:0]};
      next_page    = src_page;
      next_bank    = src_page[sdram_sched_pkg::BANK_W-1:0];
    end
  end

endmodule

/* design/command_issue.sv */
`timescale 1ns/1ps

module command_issue (
  input  logic                        INPUT_CLOCK,
  input  logic                        RST,
  input  logic                        refresh_strobe,
  input  logic                        rand_request,
  input  logic                        bulk_request,
  input  logic                        hit_any,
  input  logic                        access_write,
  input  logic                        page_open,
  input  logic                        last_was_write,
  input  sdram_sched_pkg::sdram_cmd_e latched_cmd,
  input  logic                        refresh_ack,
  output logic                        issue,
  output sdram_sched_pkg::sdram_cmd_e issue_cmd,
  output logic                        refresh_pending
);

  logic                                second_stroke; // low right after an issue
  logic                                wait_n;        // spacing not yet done
  logic                                access_burst;  // last issue was READ/WRTE
  logic [sdram_sched_pkg::CNT_W-1:0]   counter;
  logic [sdram_sched_pkg::ACTV_W-1:0]  actv_timer;
  logic                                norm_done;
  logic                                delay_done;
  logic                                wait_next_n;
  logic                                on_page_ok;
  logic                                override_ok;
  sdram_sched_pkg::sdram_cmd_e         cmd_non_access;

  // ----------------------------------------------------------------------
  // command choice
  // ----------------------------------------------------------------------
  always_comb
  begin
    if (page_open && actv_timer[sdram_sched_pkg::ACTV_W-1])
      cmd_non_access = sdram_sched_pkg::PRCH;
    else if (page_open)
      cmd_non_access = sdram_sched_pkg::NOOP; // tRAS still running
    else if (refresh_pending)
      cmd_non_access = sdram_sched_pkg::ARSR;
    else
      cmd_non_access = sdram_sched_pkg::ACTV;
  end

  assign issue_cmd = hit_any ?
                     (access_write ? sdram_sched_pkg::WRTE : sdram_sched_pkg::READ) :
                     cmd_non_access;

  // ----------------------------------------------------------------------
  // issue decision
  // ----------------------------------------------------------------------
  // each done window is two counts wide
  assign norm_done  = (counter == sdram_sched_pkg::CNT_DONE_NORM) ||
                      (counter == sdram_sched_pkg::CNT_DONE_NORM + 1'b1);
  assign delay_done = (counter == sdram_sched_pkg::CNT_DONE_DELAY) ||
                      (counter == sdram_sched_pkg::CNT_DONE_DELAY + 1'b1);

  always_comb
  begin
    if (!second_stroke)
      wait_next_n = 1'b1;
    else if (!hit_any && page_open && last_was_write)
      wait_next_n = !delay_done; // write recovery before PRCH
    else
      wait_next_n = !norm_done;
  end

  // same-type access back to back
  assign on_page_ok  = second_stroke && access_burst &&
                       (last_was_write ? access_write : !access_write);
  assign override_ok = second_stroke && !wait_n &&
                       (rand_request || bulk_request || refresh_pending);

  assign issue = (hit_any && on_page_ok) || override_ok;

  // ----------------------------------------------------------------------
  // sequential state
  // ----------------------------------------------------------------------
  always_ff @(posedge INPUT_CLOCK)
  begin
    if (!RST)
    begin
      second_stroke   <= 1'b1;
      wait_n          <= 1'b1;
      access_burst    <= 1'b0;
      counter         <= sdram_sched_pkg::CNT_RELOAD_IDLE;
      actv_timer      <= sdram_sched_pkg::ACTV_MIN;
      refresh_pending <= 1'b0;
    end
    else
    begin
      refresh_pending <= refresh_strobe ^ refresh_ack; // one ARSR per toggle
      second_stroke   <= !issue;

      if (!second_stroke && (latched_cmd == sdram_sched_pkg::ACTV))
        actv_timer <= '0;
      else if (!actv_timer[sdram_sched_pkg::ACTV_W-1])
        actv_timer <= actv_timer + 1'b1;

      // reload on the cycle the command is on the bus
      if (!second_stroke)
      begin
        case (latched_cmd)
          sdram_sched_pkg::ARSR: counter <= sdram_sched_pkg::CNT_RELOAD_ARSR;
          sdram_sched_pkg::NOOP: counter <= sdram_sched_pkg::CNT_RELOAD_IDLE;
          default:               counter <= sdram_sched_pkg::CNT_RELOAD_CMD;
        endcase
      end
      else
        counter <= counter + {{(sdram_sched_pkg::CNT_W-1){1'b0}}, wait_n};

      if (issue)
      begin
        wait_n       <= 1'b1;
        access_burst <= hit_any;
      end
      else
        wait_n <= wait_next_n;
    end
  end

endmodule

/* design/bank_state_tracker.sv */
`timescale 1ns/1ps

module bank_state_tracker (
  input  logic                                  INPUT_CLOCK,
  input  logic                                  RST,
  input  logic                                  issue,
  input  sdram_sched_pkg::sdram_cmd_e           issue_cmd,
  input  logic                                  hit_rand,
  input  logic                                  hit_bulk,
  input  logic [sdram_sched_pkg::PAGE_W-1:0]    next_page,
  input  logic [sdram_sched_pkg::SD_ADDR_W-1:0] next_sd_addr,
  input  logic [sdram_sched_pkg::BANK_W-1:0]    next_bank,
  input  logic [sdram_sched_pkg::WE_W-1:0]      rand_we_array,
  input  logic [sdram_sched_pkg::WE_W-1:0]      bulk_we_array,
  input  logic                                  refresh_strobe,
  output sdram_sched_pkg::sdram_cmd_e           sdram_command,
  output logic [sdram_sched_pkg::SD_ADDR_W-1:0] sdram_address,
  output logic [sdram_sched_pkg::BANK_W-1:0]    sdram_bank,
  output logic                                  rand_grant,
  output logic                                  bulk_grant,
  output logic [sdram_sched_pkg::WE_W-1:0]      we_array_out,
  output sdram_sched_pkg::sdram_cmd_e           latched_cmd,
  output logic                                  page_open,
  output logic [sdram_sched_pkg::PAGE_W-1:0]    open_page,
  output logic                                  last_was_write,
  output logic                                  refresh_ack
);

  sdram_sched_pkg::sdram_cmd_e cmd_q;
  logic                        hit_any;
  logic                        page_mismatch;

  assign hit_any       = hit_rand || hit_bulk;
  assign page_mismatch = page_open && !hit_any;

  // same register feeds the bus and the issue logic
  assign sdram_command = cmd_q;
  assign latched_cmd   = cmd_q;

  // ----------------------------------------------------------------------
  // command, address and grants
  // ----------------------------------------------------------------------
  always_ff @(posedge INPUT_CLOCK)
  begin
    if (!RST)
    begin
      cmd_q         <= sdram_sched_pkg::NOOP;
      sdram_address <= sdram_sched_pkg::PRCH_ALL_ADDR;
      sdram_bank    <= '0;
      rand_grant    <= 1'b0;
      bulk_grant    <= 1'b0;
    end
    else
    begin
      cmd_q <= issue ? issue_cmd : sdram_sched_pkg::NOOP;

      // wrong page open, keep A10 up for the coming PRCH
      if (page_mismatch)
        sdram_address <= sdram_sched_pkg::PRCH_ALL_ADDR;
      else if (issue)
      begin
        sdram_address <= next_sd_addr;
        sdram_bank    <= next_bank;
      end

      // grant only with the access itself
      rand_grant <= issue && hit_rand;
      bulk_grant <= issue && hit_bulk;
    end
  end

  // payload, qualified by page_open and the grants
  always_ff @(posedge INPUT_CLOCK)
  begin
    if (!page_mismatch && issue)
      open_page <= next_page;
    if (issue)
      we_array_out <= hit_bulk ? bulk_we_array : rand_we_array;
  end

  // ----------------------------------------------------------------------
  // bank state, follows the command on the bus
  // ----------------------------------------------------------------------
  always_ff @(posedge INPUT_CLOCK)
  begin
    if (!RST)
    begin
      page_open      <= 1'b0;
      last_was_write <= 1'b0;
      refresh_ack    <= 1'b0;
    end
    else
    begin
      case (cmd_q)
        sdram_sched_pkg::ACTV:
          page_open <= 1'b1;
        sdram_sched_pkg::PRCH:
          page_open <= 1'b0;
        sdram_sched_pkg::ARSR:
          refresh_ack <= refresh_strobe; // strobe level now served
        default:
          ;
      endcase

      if (cmd_q == sdram_sched_pkg::WRTE)
        last_was_write <= 1'b1;
      else if (cmd_q != sdram_sched_pkg::NOOP)
        last_was_write <= 1'b0;
    end
  end

endmodule

/* design/sdram_sched_top.sv */
`timescale 1ns/1ps

module sdram_sched_top (
  input  logic                                  INPUT_CLOCK,
  input  logic                                  RST,
  input  logic                                  refresh_strobe,
  // random port
  input  logic [sdram_sched_pkg::ADDR_W-1:0]    rand_address,
  input  logic                                  rand_we,
  input  logic                                  rand_request,
  input  logic [sdram_sched_pkg::WE_W-1:0]      rand_we_array,
  output logic                                  rand_grant,
  // bulk port
  input  logic [sdram_sched_pkg::ADDR_W-1:0]    bulk_address,
  input  logic                                  bulk_we,
  input  logic                                  bulk_request,
  input  logic [sdram_sched_pkg::WE_W-1:0]      bulk_we_array,
  output logic                                  bulk_grant,
  // SDRAM side
  output logic [sdram_sched_pkg::SD_ADDR_W-1:0] sdram_address,
  output logic [sdram_sched_pkg::BANK_W-1:0]    sdram_bank,
  output sdram_sched_pkg::sdram_cmd_e           sdram_command,
  output logic [sdram_sched_pkg::WE_W-1:0]      we_array_out
);

  logic                                  hit_rand;
  logic                                  hit_bulk;
  logic                                  hit_any;
  logic                                  access_write;
  logic [sdram_sched_pkg::PAGE_W-1:0]    next_page;
  logic [sdram_sched_pkg::SD_ADDR_W-1:0] next_sd_addr;
  logic [sdram_sched_pkg::BANK_W-1:0]    next_bank;
  logic                                  issue;
  sdram_sched_pkg::sdram_cmd_e           issue_cmd;
  logic                                  refresh_pending;
  sdram_sched_pkg::sdram_cmd_e           latched_cmd;
  logic                                  page_open;
  logic [sdram_sched_pkg::PAGE_W-1:0]    open_page;
  logic                                  last_was_write;
  logic                                  refresh_ack;

  page_hit_decode u_page_hit_decode (
    .rand_address    (rand_address),
    .rand_request    (rand_request),
    .rand_we         (rand_we),
    .bulk_address    (bulk_address),
    .bulk_request    (bulk_request),
    .bulk_we         (bulk_we),
    .page_open       (page_open),
    .open_page       (open_page),
    .refresh_pending (refresh_pending),
    .hit_rand        (hit_rand),
    .hit_bulk        (hit_bulk),
    .hit_any         (hit_any),
    .access_write    (access_write),
    .next_page       (next_page),
    .next_sd_addr    (next_sd_addr),
    .next_bank       (next_bank)
  );

  command_issue u_command_issue (
    .INPUT_CLOCK     (INPUT_CLOCK),
    .RST             (RST),
    .refresh_strobe  (refresh_strobe),
    .rand_request    (rand_request),
    .bulk_request    (bulk_request),
    .hit_any         (hit_any),
    .access_write    (access_write),
    .page_open       (page_open),
    .last_was_write  (last_was_write),
    .latched_cmd     (latched_cmd),
    .refresh_ack     (refresh_ack),
    .issue           (issue),
    .issue_cmd       (issue_cmd),
    .refresh_pending (refresh_pending)
  );

  bank_state_tracker u_bank_state_tracker (
    .INPUT_CLOCK     (INPUT_CLOCK),
    .RST             (RST),
    .issue           (issue),
    .issue_cmd       (issue_cmd),
    .hit_rand        (hit_rand),
    .hit_bulk        (hit_bulk),
    .next_page       (next_page),
    .next_sd_addr    (next_sd_addr),
    .next_bank       (next_bank),
    .rand_we_array   (rand_we_array),
    .bulk_we_array   (bulk_we_array),
    .refresh_strobe  (refresh_strobe),
    .sdram_command   (sdram_command),
    .sdram_address   (sdram_address),
    .sdram_bank      (sdram_bank),
    .rand_grant      (rand_grant),
    .bulk_grant      (bulk_grant),
    .we_array_out    (we_array_out),
    .latched_cmd     (latched_cmd),
    .page_open       (page_open),
    .open_page       (open_page),
    .last_was_write  (last_was_write),
    .refresh_ack     (refresh_ack)
  );

endmodule

/* bench/sdram_sched_ref.svh */
`ifndef SDRAM_SCHED_REF_SVH
`define SDRAM_SCHED_REF_SVH

// ----------------------------------------------------------------------
// expected bus state for the next issued command
// ----------------------------------------------------------------------

// A10 stays low on a row address, upper row bits sit above it
function automatic logic [12:0] row_bus_address(input logic [11:0] row);
  row_bus_address = {row[11:10], 1'b0, row[9:0]};
endfunction

function automatic void predict_command(
  input  logic                        page_open,
  input  logic [13:0]                 open_page,
  input  logic                        refresh_owed,
  input  logic                        rand_req,
  input  logic [25:0]                 rand_addr,
  input  logic                        rand_wr,
  input  logic                        bulk_req,
  input  logic [25:0]                 bulk_addr,
  input  logic                        bulk_wr,
  output sdram_sched_pkg::sdram_cmd_e cmd,
  output logic [12:0]                 addr,
  output logic [1:0]                  bank,
  output logic [13:0]                 page,
  output logic                        rand_g,
  output logic                        bulk_g
);
  logic [25:0] src;
  logic        src_wr;
  logic        hit;

  src    = bulk_req ? bulk_addr : rand_addr; // bulk port first
  src_wr = bulk_req ? bulk_wr : rand_wr;
  hit    = (bulk_req || rand_req) && page_open && !refresh_owed &&
           (src[25:12] == open_page);
  rand_g = hit && !bulk_req;
  bulk_g = hit && bulk_req;
  cmd    = sdram_sched_pkg::NOOP;
  addr   = 13'h0400; // precharge all
  bank   = open_page[1:0];
  page   = open_page;
  if (hit)
  begin
    cmd  = src_wr ? sdram_sched_pkg::WRTE : sdram_sched_pkg::READ;
    addr = {src[11:0], 1'b0}; // column in 16-bit halves
  end
  else if (page_open)
    cmd = sdram_sched_pkg::PRCH;
  else if (refresh_owed)
    cmd = sdram_sched_pkg::ARSR;
  else
  begin
    cmd  = sdram_sched_pkg::ACTV;
    addr = row_bus_address(src[25:14]);
    bank = src[13:12];
    page = src[25:12];
  end
endfunction

task automatic check_value(input string test, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
  if (expected !== actual)
  begin
    $display("ERR %s %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first mismatch");
  end
endtask

`endif

/* bench/sdram_sched_tb.sv */
`timescale 1ns/1ps

module sdram_sched_tb;

  localparam int RESET_CYCLES = 10;
  localparam int RAND_REQS    = 8;
  localparam int NUM_REQUESTS = 8 + RAND_REQS; // refresh counted as one
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 40 * NUM_REQUESTS;
  localparam logic [13:0] PAGE_A = {12'h5a3, 2'd1}; // A10 set in the row
  localparam logic [13:0] PAGE_B = {12'h0c7, 2'd2};
  localparam logic [13:0] PAGE_C = {12'h123, 2'd2};

  logic                                  INPUT_CLOCK;
  logic                                  RST;
  logic                                  refresh_strobe;
  logic [sdram_sched_pkg::ADDR_W-1:0]    rand_address;
  logic                                  rand_we;
  logic                                  rand_request;
  logic [sdram_sched_pkg::WE_W-1:0]      rand_we_array;
  logic                                  rand_grant;
  logic [sdram_sched_pkg::ADDR_W-1:0]    bulk_address;
  logic                                  bulk_we;
  logic                                  bulk_request;
  logic [sdram_sched_pkg::WE_W-1:0]      bulk_we_array;
  logic                                  bulk_grant;
  logic [sdram_sched_pkg::SD_ADDR_W-1:0] sdram_address;
  logic [sdram_sched_pkg::BANK_W-1:0]    sdram_bank;
  sdram_sched_pkg::sdram_cmd_e           sdram_command;
  logic [sdram_sched_pkg::WE_W-1:0]      we_array_out;

  string  test_name = "reset";
  integer seed = 5290;
  int     cycle_count = 0;
  int     toggles_sent = 0;
  int     arsr_seen = 0;
  int     grants_seen = 0;
  int     requests_done = 0;
  int     i;
  logic [31:0] rnd;

  // reference model state and the inputs of the decision cycle
  logic                        ref_page_open = 1'b0;
  logic [13:0]                 ref_open_page = '0;
  sdram_sched_pkg::sdram_cmd_e prev_cmd = sdram_sched_pkg::NOOP;
  logic                        snap_owed, snap_rand_req, snap_rand_we, snap_bulk_req, snap_bulk_we;
  logic [25:0]                 snap_rand_addr, snap_bulk_addr;
  logic [3:0]                  snap_rand_wea, snap_bulk_wea;
  sdram_sched_pkg::sdram_cmd_e exp_cmd;
  logic [12:0]                 exp_addr;
  logic [1:0]                  exp_bank;
  logic [13:0]                 exp_page;
  logic                        exp_rand_g, exp_bulk_g;

  `include "sdram_sched_ref.svh"

  sdram_sched_top u_sdram_sched_top (.*);

  initial
  begin
    INPUT_CLOCK = 1'b0;
    forever #20 INPUT_CLOCK = ~INPUT_CLOCK;
  end

  always @(posedge INPUT_CLOCK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout in test %s after %0d cycles", test_name, cycle_count);
      $display("STATUS: FAIL");
      $fatal(1, "no progress");
    end
  end

  // ----------------------------------------------------------------------
  // monitor, one compare per bus cycle
  // ----------------------------------------------------------------------
  always @(negedge INPUT_CLOCK)
  begin
    if (RST)
    begin
      if (prev_cmd != sdram_sched_pkg::NOOP)
        check_value(test_name, "gap after command", 32'(sdram_sched_pkg::NOOP),
                    32'(sdram_command));
      if (sdram_command == sdram_sched_pkg::NOOP)
      begin
        check_value(test_name, "rand_grant idle", 32'd0, 32'(rand_grant));
        check_value(test_name, "bulk_grant idle", 32'd0, 32'(bulk_grant));
      end
      else
      begin
        predict_command(ref_page_open, ref_open_page, snap_owed,
                        snap_rand_req, snap_rand_addr, snap_rand_we,
                        snap_bulk_req, snap_bulk_addr, snap_bulk_we,
                        exp_cmd, exp_addr, exp_bank, exp_page, exp_rand_g, exp_bulk_g);
        check_value(test_name, "command", 32'(exp_cmd), 32'(sdram_command));
        check_value(test_name, "rand_grant", 32'(exp_rand_g), 32'(rand_grant));
        check_value(test_name, "bulk_grant", 32'(exp_bulk_g), 32'(bulk_grant));
        if (exp_cmd != sdram_sched_pkg::ARSR)
        begin
          check_value(test_name, "address", 32'(exp_addr), 32'(sdram_address));
          check_value(test_name, "bank", 32'(exp_bank), 32'(sdram_bank));
        end
        case (exp_cmd)
          sdram_sched_pkg::ACTV:
          begin
            ref_page_open = 1'b1;
            ref_open_page = exp_page;
          end
          sdram_sched_pkg::PRCH: ref_page_open = 1'b0;
          sdram_sched_pkg::ARSR: arsr_seen++;
          default:
          begin
            check_value(test_name, "we_array_out",
                        32'(exp_bulk_g ? snap_bulk_wea : snap_rand_wea), 32'(we_array_out));
            grants_seen++;
          end
        endcase
      end
    end
    prev_cmd       = sdram_command;
    snap_owed      = (toggles_sent > arsr_seen);
    snap_rand_req  = rand_request;
    snap_rand_addr = rand_address;
    snap_rand_we   = rand_we;
    snap_rand_wea  = rand_we_array;
    snap_bulk_req  = bulk_request;
    snap_bulk_addr = bulk_address;
    snap_bulk_we   = bulk_we;
    snap_bulk_wea  = bulk_we_array;
  end

  // ----------------------------------------------------------------------
  // requester side
  // ----------------------------------------------------------------------
  task automatic start_request(input logic bulk_side, input logic [25:0] addr,
                               input logic wr, input logic [3:0] wea);
    if (bulk_side)
    begin
      bulk_address  <= addr;
      bulk_we       <= wr;
      bulk_we_array <= wea;
      bulk_request  <= 1'b1;
    end
    else
    begin
      rand_address  <= addr;
      rand_we       <= wr;
      rand_we_array <= wea;
      rand_request  <= 1'b1;
    end
  endtask

  task automatic end_request(input logic bulk_side);
    if (bulk_side)
      bulk_request <= 1'b0;
    else
      rand_request <= 1'b0;
    requests_done++;
  endtask

  task automatic wait_for_grant(input logic bulk_side);
    @(negedge INPUT_CLOCK);
    while ((bulk_side ? bulk_grant : rand_grant) !== 1'b1)
      @(negedge INPUT_CLOCK);
  endtask

  task automatic run_request(input logic bulk_side, input logic [25:0] addr,
                             input logic wr, input logic [3:0] wea);
    @(posedge INPUT_CLOCK);
    start_request(bulk_side, addr, wr, wea);
    wait_for_grant(bulk_side);
    @(posedge INPUT_CLOCK);
    end_request(bulk_side);
  endtask

  task automatic refresh_with_open_page(input logic [25:0] addr, input logic [3:0] wea);
    int grants_before;
    grants_before = grants_seen;
    check_value(test_name, "page open before toggle", 32'd1, 32'(ref_page_open));
    @(posedge INPUT_CLOCK);
    refresh_strobe <= ~refresh_strobe; // one toggle, one ARSR
    toggles_sent++;
    @(posedge INPUT_CLOCK);
    start_request(1'b0, addr, 1'b0, wea); // hits the open page, must wait
    while (arsr_seen != toggles_sent)
      @(negedge INPUT_CLOCK);
    check_value(test_name, "grants during refresh", 32'(grants_before), 32'(grants_seen));
    wait_for_grant(1'b0);
    @(posedge INPUT_CLOCK);
    end_request(1'b0);
  endtask

  initial
  begin
    RST            = 1'b0;
    refresh_strobe = 1'b0;
    rand_address   = '0;
    rand_we        = 1'b0;
    rand_request   = 1'b0;
    rand_we_array  = '0;
    bulk_address   = '0;
    bulk_we        = 1'b0;
    bulk_request   = 1'b0;
    bulk_we_array  = '0;
    repeat (RESET_CYCLES) @(posedge INPUT_CLOCK);
    RST <= 1'b1;

    repeat (3) @(negedge INPUT_CLOCK); // idle bus, nothing requested
    check_value(test_name, "command", 32'(sdram_sched_pkg::NOOP), 32'(sdram_command));
    check_value(test_name, "address", 32'h0400, 32'(sdram_address));
    check_value(test_name, "bank", 32'd0, 32'(sdram_bank));
    check_value(test_name, "rand_grant", 32'd0, 32'(rand_grant));
    check_value(test_name, "bulk_grant", 32'd0, 32'(bulk_grant));

    test_name = "rand_read_closed";
    rnd = $random(seed);
    run_request(1'b0, {PAGE_C, rnd[11:0]}, 1'b0, rnd[15:12]);
    test_name = "bulk_write_open";
    rnd = $random(seed);
    run_request(1'b1, {PAGE_C, rnd[11:0]}, 1'b1, rnd[15:12]);
    test_name = "row_change";
    rnd = $random(seed);
    run_request(1'b0, {PAGE_B, rnd[11:0]}, 1'b0, rnd[15:12]);
    test_name = "refresh";
    rnd = $random(seed);
    refresh_with_open_page({PAGE_B, rnd[11:0]}, rnd[15:12]);
    rnd = $random(seed);
    run_request(1'b0, {PAGE_A, rnd[11:0]}, 1'b1, rnd[15:12]);

    // both ports on the open page, bulk goes first
    test_name = "both_ports";
    rnd = $random(seed);
    @(posedge INPUT_CLOCK);
    start_request(1'b1, {PAGE_A, rnd[11:0]}, 1'b1, rnd[15:12]);
    start_request(1'b0, {PAGE_A, rnd[27:16]}, 1'b0, rnd[31:28]);
    wait_for_grant(1'b1);
    @(posedge INPUT_CLOCK);
    end_request(1'b1);
    wait_for_grant(1'b0);
    @(posedge INPUT_CLOCK);
    end_request(1'b0);

    test_name = "random_mix";
    for (i = 0; i < RAND_REQS; i++)
    begin
      rnd = $random(seed);
      run_request(rnd[2], {(rnd[0] ? PAGE_A : PAGE_B), rnd[15:4]}, rnd[1], rnd[19:16]);
    end

    test_name = "totals";
    check_value(test_name, "ARSR count", 32'(toggles_sent), 32'(arsr_seen));
    check_value(test_name, "grant count", 32'(requests_done), 32'(grants_seen));
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+bench
design/sdram_sched_pkg.sv
design/page_hit_decode.sv
design/command_issue.sv
design/bank_state_tracker.sv
design/sdram_sched_top.sv
bench/sdram_sched_tb.sv

/* Makefile */
TOP = sdram_sched_tb

all: run

compile:
	verilator --binary -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
